/* build.f */
src/exec_pkg.sv
src/thread_queue.sv
src/exec_lane.sv
src/result_router.sv
src/exec_stage.sv
tests/exec_stage_properties.sv
tests/exec_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the exec_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f build.f \
	--top-module exec_stage_tb \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit $status
fi

./obj_dir/Vexec_stage_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

/* src/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane #(
	parameter int num_threads = 4
) (
	input  exec_pkg::thread_id_t dispatch_thread,
	input  logic                 head_valid [num_threads],
	input  exec_pkg::word_t      head_pc    [num_threads],
	input  exec_pkg::alu_op_e    head_op    [num_threads],
	input  exec_pkg::word_t      head_op1   [num_threads],
	input  exec_pkg::word_t      head_op2   [num_threads],
	input  exec_pkg::word_t      head_imm   [num_threads],
	input  exec_pkg::reg_addr_t  head_rd    [num_threads],
	output exec_pkg::thread_id_t lane_thread,
	output logic                 lane_wb_en,
	output exec_pkg::reg_addr_t  lane_rd,
	output exec_pkg::word_t      lane_data,
	output logic                 lane_jump,
	output exec_pkg::word_t      lane_target
);
	import exec_pkg::*;

	logic      active;
	word_t     pc;
	alu_op_e   op;
	word_t     a;
	word_t     b;
	word_t     imm;
	reg_addr_t rd;
	logic      wb;
	logic      jmp;

	always_comb begin
		active = 1'b0;
		pc     = '0;
		op     = op_add;
		a      = '0;
		b      = '0;
		imm    = '0;
		rd     = '0;
		for (int t = 0; t < num_threads; t++) begin
			if (dispatch_thread == thread_id_t'(t) && head_valid[t]) begin
				active = 1'b1;
				pc     = head_pc[t];
				op     = head_op[t];
				a      = head_op1[t];
				b      = head_op2[t];
				imm    = head_imm[t];
				rd     = head_rd[t];
			end
		end
	end

	always_comb begin
		wb        = 1'b1;
		jmp       = 1'b0;
		lane_data = '0;
		case (op)
			op_add: lane_data = a + b;
			op_sub: lane_data = a - b;
			op_and: lane_data = a & b;
			op_or:  lane_data = a | b;
			op_xor: lane_data = a ^ b;
			op_slt: lane_data = word_t'($signed(a) < $signed(b));
			op_beq: begin
				wb  = 1'b0;
				jmp = (a == b);
			end
			op_bne: begin
				wb  = 1'b0;
				jmp = (a != b);
			end
			op_jal: begin
				lane_data = pc + word_t'(link_offset);    // link address
				jmp       = 1'b1;
			end
			default: wb = 1'b0;
		endcase
	end

	assign lane_thread = active ? dispatch_thread : thread_id_t'(num_threads);
	assign lane_wb_en  = active && wb;
	assign lane_jump   = active && jmp;
	assign lane_rd     = rd;
	assign lane_target = pc + imm;

endmodule

/* src/exec_pkg.sv */
package exec_pkg;

	localparam int xlen        = 32;
	localparam int reg_addr_w  = 5;
	localparam int max_threads = 8;
	localparam int queue_depth = 3;    // entries per thread queue
	localparam int link_offset = 4;    // jal link is pc + 4

	typedef logic [xlen-1:0]       word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// one code above the highest thread number marks an idle lane
	typedef logic [$clog2(max_threads):0] thread_id_t;

	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or  = 4'd3,
		op_xor = 4'd4,
		op_slt = 4'd5,    // signed compare
		op_beq = 4'd6,
		op_bne = 4'd7,
		op_jal = 4'd8
	} alu_op_e;

endpackage

/* src/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage #(
	parameter int num_threads = 4,
	parameter int num_lanes   = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 id_valid        [num_threads],
	input  exec_pkg::word_t      id_pc           [num_threads],
	input  exec_pkg::alu_op_e    id_op           [num_threads],
	input  exec_pkg::word_t      id_op1          [num_threads],
	input  exec_pkg::word_t      id_op2          [num_threads],
	input  exec_pkg::word_t      id_imm          [num_threads],
	input  exec_pkg::reg_addr_t  id_rd           [num_threads],
	input  exec_pkg::reg_addr_t  id_rs1          [num_threads],
	input  exec_pkg::reg_addr_t  id_rs2          [num_threads],
	output logic                 id_stall        [num_threads],
	input  exec_pkg::thread_id_t dispatch_thread [num_lanes],
	output logic                 wb_en           [num_threads],
	output exec_pkg::reg_addr_t  wb_rd           [num_threads],
	output exec_pkg::word_t      wb_data         [num_threads],
	output logic                 jump_en         [num_threads],
	output exec_pkg::word_t      jump_addr       [num_threads]
);
	import exec_pkg::*;

	logic      head_valid [num_threads];
	word_t     head_pc    [num_threads];
	alu_op_e   head_op    [num_threads];
	word_t     head_op1   [num_threads];
	word_t     head_op2   [num_threads];
	word_t     head_imm   [num_threads];
	reg_addr_t head_rd    [num_threads];

	thread_id_t lane_thread [num_lanes];
	logic       lane_wb_en  [num_lanes];
	reg_addr_t  lane_rd     [num_lanes];
	word_t      lane_data   [num_lanes];
	logic       lane_jump   [num_lanes];
	word_t      lane_target [num_lanes];

	for (genvar t = 0; t < num_threads; t++) begin : g_thread
		thread_queue #(
			.num_threads  (num_threads),
			.num_lanes    (num_lanes),
			.thread_index (t)
		) queue_i (
			.clk             (clk),
			.rst             (rst),
			.id_valid        (id_valid[t]),
			.id_pc           (id_pc[t]),
			.id_op           (id_op[t]),
			.id_op1          (id_op1[t]),
			.id_op2          (id_op2[t]),
			.id_imm          (id_imm[t]),
			.id_rd           (id_rd[t]),
			.id_rs1          (id_rs1[t]),
			.id_rs2          (id_rs2[t]),
			.dispatch_thread (dispatch_thread),
			.wb_en           (wb_en[t]),    // own writeback for forwarding
			.wb_rd           (wb_rd[t]),
			.wb_data         (wb_data[t]),
			.jump_en         (jump_en[t]),
			.id_stall        (id_stall[t]),
			.head_valid      (head_valid[t]),
			.head_pc         (head_pc[t]),
			.head_op         (head_op[t]),
			.head_op1        (head_op1[t]),
			.head_op2        (head_op2[t]),
			.head_imm        (head_imm[t]),
			.head_rd         (head_rd[t])
		);
	end

	// two lanes
	for (genvar l = 0; l < 2; l++) begin : g_lane
		exec_lane #(
			.num_threads (num_threads)
		) lane_i (
			.dispatch_thread (dispatch_thread[l]),
			.head_valid      (head_valid),
			.head_pc         (head_pc),
			.head_op         (head_op),
			.head_op1        (head_op1),
			.head_op2        (head_op2),
			.head_imm        (head_imm),
			.head_rd         (head_rd),
			.lane_thread     (lane_thread[l]),
			.lane_wb_en      (lane_wb_en[l]),
			.lane_rd         (lane_rd[l]),
			.lane_data       (lane_data[l]),
			.lane_jump       (lane_jump[l]),
			.lane_target     (lane_target[l])
		);
	end

	result_router #(
		.num_threads (num_threads),
		.num_lanes   (num_lanes)
	) router_i (
		.clk         (clk),
		.rst         (rst),
		.lane_thread (lane_thread),
		.lane_wb_en  (lane_wb_en),
		.lane_rd     (lane_rd),
		.lane_data   (lane_data),
		.lane_jump   (lane_jump),
		.lane_target (lane_target),
		.wb_en       (wb_en),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.jump_en     (jump_en),
		.jump_addr   (jump_addr)
	);

endmodule

/* src/result_router.sv */
`timescale 1ns/1ps

module result_router #(
	parameter int num_threads = 4,
	parameter int num_lanes   = 2
) (
	input  logic                 clk,
	input  logic                 rst,
	input  exec_pkg::thread_id_t lane_thread [num_lanes],
	input  logic                 lane_wb_en  [num_lanes],
	input  exec_pkg::reg_addr_t  lane_rd     [num_lanes],
	input  exec_pkg::word_t      lane_data   [num_lanes],
	input  logic                 lane_jump   [num_lanes],
	input  exec_pkg::word_t      lane_target [num_lanes],
	output logic                 wb_en       [num_threads],
	output exec_pkg::reg_addr_t  wb_rd       [num_threads],
	output exec_pkg::word_t      wb_data     [num_threads],
	output logic                 jump_en     [num_threads],
	output exec_pkg::word_t      jump_addr   [num_threads]
);
	import exec_pkg::*;

	thread_id_t r_thread [num_lanes];
	logic       r_wb_en  [num_lanes];
	logic       r_jump   [num_lanes];
	reg_addr_t  r_rd     [num_lanes];
	word_t      r_data   [num_lanes];
	word_t      r_target [num_lanes];

	always_ff @(posedge clk) begin
		for (int l = 0; l < num_lanes; l++) begin
			if (!rst) begin
				r_thread[l] <= thread_id_t'(num_threads);    // idle
				r_wb_en[l]  <= 1'b0;
				r_jump[l]   <= 1'b0;
			end else begin
				r_thread[l] <= lane_thread[l];
				r_wb_en[l]  <= lane_wb_en[l];
				r_jump[l]   <= lane_jump[l];
			end
		end
	end

	always_ff @(posedge clk) begin
		r_rd     <= lane_rd;
		r_data   <= lane_data;
		r_target <= lane_target;
	end

	always_comb begin
		for (int t = 0; t < num_threads; t++) begin
			wb_en[t]     = 1'b0;
			wb_rd[t]     = '0;
			wb_data[t]   = '0;
			jump_en[t]   = 1'b0;
			jump_addr[t] = '0;
		end
		for (int l = 0; l < num_lanes; l++) begin
			for (int t = 0; t < num_threads; t++) begin
				if (r_thread[l] == thread_id_t'(t)) begin
					wb_en[t]     = r_wb_en[l];
					wb_rd[t]     = r_rd[l];
					wb_data[t]   = r_data[l];
					jump_en[t]   = r_jump[l];
					jump_addr[t] = r_target[l];
				end
			end
		end
	end

endmodule

/* src/thread_queue.sv */
`timescale 1ns/1ps

module thread_queue #(
	parameter int num_threads  = 4,
	parameter int num_lanes    = 2,
	parameter int thread_index = 0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 id_valid,
	input  exec_pkg::word_t      id_pc,
	input  exec_pkg::alu_op_e    id_op,
	input  exec_pkg::word_t      id_op1,
	input  exec_pkg::word_t      id_op2,
	input  exec_pkg::word_t      id_imm,
	input  exec_pkg::reg_addr_t  id_rd,
	input  exec_pkg::reg_addr_t  id_rs1,
	input  exec_pkg::reg_addr_t  id_rs2,
	input  exec_pkg::thread_id_t dispatch_thread [num_lanes],
	input  logic                 wb_en,
	input  exec_pkg::reg_addr_t  wb_rd,
	input  exec_pkg::word_t      wb_data,
	input  logic                 jump_en,
	output logic                 id_stall,
	output logic                 head_valid,
	output exec_pkg::word_t      head_pc,
	output exec_pkg::alu_op_e    head_op,
	output exec_pkg::word_t      head_op1,
	output exec_pkg::word_t      head_op2,
	output exec_pkg::word_t      head_imm,
	output exec_pkg::reg_addr_t  head_rd
);
	import exec_pkg::*;

	localparam int cnt_w = $clog2(queue_depth + 1);
	localparam thread_id_t my_id = thread_id_t'(thread_index);

	logic [queue_depth-1:0] q_valid;
	word_t     q_pc  [queue_depth];
	alu_op_e   q_op  [queue_depth];
	word_t     q_op1 [queue_depth];
	word_t     q_op2 [queue_depth];
	word_t     q_imm [queue_depth];
	reg_addr_t q_rd  [queue_depth];
	reg_addr_t q_rs1 [queue_depth];
	reg_addr_t q_rs2 [queue_depth];
	word_t     last_pc;    // pc of the last accepted instruction
	logic      last_vld;

	word_t e_op1 [queue_depth];    // stored operands after forwarding
	word_t e_op2 [queue_depth];
	word_t in_op1;
	word_t in_op2;

	logic [queue_depth-1:0] n_valid;
	word_t     n_pc  [queue_depth];
	alu_op_e   n_op  [queue_depth];
	word_t     n_op1 [queue_depth];
	word_t     n_op2 [queue_depth];
	word_t     n_imm [queue_depth];
	reg_addr_t n_rd  [queue_depth];
	reg_addr_t n_rs1 [queue_depth];
	reg_addr_t n_rs2 [queue_depth];

	logic pop;
	logic empty;
	logic full;
	logic new_ins;
	logic accept;
	logic shift;
	logic store;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] wr_idx;

	function automatic word_t fwd(input reg_addr_t rs, input word_t val);
		if (wb_en && wb_rd != '0 && wb_rd == rs)
			return wb_data;
		return val;
	endfunction

	always_comb begin
		pop = 1'b0;
		for (int l = 0; l < num_lanes; l++) begin
			if (dispatch_thread[l] == my_id)
				pop = 1'b1;
		end
	end

	always_comb begin
		cnt = '0;
		for (int i = 0; i < queue_depth; i++) begin
			if (q_valid[i])
				cnt = cnt + cnt_w'(1);
		end
	end

	assign empty    = !q_valid[0];
	assign full     = q_valid[queue_depth-1];
	assign new_ins  = id_valid && (!last_vld || id_pc != last_pc);    // repeat filter
	assign accept   = new_ins && !jump_en && (!full || pop);
	assign shift    = pop && !empty;
	assign store    = accept && !(pop && empty);    // bypassed head is not stored
	assign wr_idx   = shift ? cnt - cnt_w'(1) : cnt;
	assign id_stall = full && !pop;

	always_comb begin
		for (int i = 0; i < queue_depth; i++) begin
			e_op1[i] = fwd(q_rs1[i], q_op1[i]);
			e_op2[i] = fwd(q_rs2[i], q_op2[i]);
		end
		in_op1 = fwd(id_rs1, id_op1);
		in_op2 = fwd(id_rs2, id_op2);
	end

	// empty queue hands the incoming instruction straight to the lanes
	assign head_valid = empty ? new_ins : 1'b1;
	assign head_pc    = empty ? id_pc : q_pc[0];
	assign head_op    = empty ? id_op : q_op[0];
	assign head_op1   = empty ? in_op1 : e_op1[0];
	assign head_op2   = empty ? in_op2 : e_op2[0];
	assign head_imm   = empty ? id_imm : q_imm[0];
	assign head_rd    = empty ? id_rd : q_rd[0];

	always_comb begin
		n_valid = q_valid;
		n_pc    = q_pc;
		n_op    = q_op;
		n_op1   = e_op1;
		n_op2   = e_op2;
		n_imm   = q_imm;
		n_rd    = q_rd;
		n_rs1   = q_rs1;
		n_rs2   = q_rs2;
		if (shift) begin
			for (int i = 0; i < queue_depth - 1; i++) begin
				n_valid[i] = q_valid[i+1];
				n_pc[i]    = q_pc[i+1];
				n_op[i]    = q_op[i+1];
				n_op1[i]   = e_op1[i+1];
				n_op2[i]   = e_op2[i+1];
				n_imm[i]   = q_imm[i+1];
				n_rd[i]    = q_rd[i+1];
				n_rs1[i]   = q_rs1[i+1];
				n_rs2[i]   = q_rs2[i+1];
			end
			n_valid[queue_depth-1] = 1'b0;
		end
		if (store) begin    // append behind the youngest entry
			n_valid[wr_idx] = 1'b1;
			n_pc[wr_idx]    = id_pc;
			n_op[wr_idx]    = id_op;
			n_op1[wr_idx]   = in_op1;
			n_op2[wr_idx]   = in_op2;
			n_imm[wr_idx]   = id_imm;
			n_rd[wr_idx]    = id_rd;
			n_rs1[wr_idx]   = id_rs1;
			n_rs2[wr_idx]   = id_rs2;
		end
	end

	always_ff @(posedge clk) begin
		q_pc  <= n_pc;
		q_op  <= n_op;
		q_op1 <= n_op1;
		q_op2 <= n_op2;
		q_imm <= n_imm;
		q_rd  <= n_rd;
		q_rs1 <= n_rs1;
		q_rs2 <= n_rs2;
	end

	always_ff @(posedge clk) begin
		if (!rst || jump_en) begin    // flush on jump
			q_valid  <= '0;
			last_vld <= 1'b0;
			last_pc  <= '0;
		end else begin
			q_valid <= n_valid;
			if (accept) begin
				last_vld <= 1'b1;
				last_pc  <= id_pc;
			end
		end
	end

endmodule

/* tests/exec_stage_properties.sv */
`timescale 1ns/1ps

module exec_stage_properties #(
	parameter int num_threads = 4,
	parameter int num_lanes   = 2
) (
	input logic                 clk,
	input logic                 rst,
	input exec_pkg::thread_id_t dispatch_thread [num_lanes],
	input logic                 pop,
	input logic                 head_valid,
	input logic                 full,
	input exec_pkg::word_t      last_pc,
	input logic                 jump_en
);
	import exec_pkg::*;

	localparam thread_id_t idle_id = thread_id_t'(num_threads);

	// lanes never share a thread
	assert property (@(posedge clk) disable iff (!rst)
		dispatch_thread[0] == idle_id || dispatch_thread[0] != dispatch_thread[1])
		else $error("two lanes dispatched thread %0d", dispatch_thread[0]);

	assert property (@(posedge clk) disable iff (!rst) pop |-> head_valid)
		else $error("dispatch of a thread with no valid head");

	// held instruction stays outside a full queue
	assert property (@(posedge clk) disable iff (!rst)
		full && !pop && !jump_en |=> $stable(last_pc))
		else $error("instruction captured into a full queue");

	assert property (@(posedge clk) disable iff (!rst) jump_en |-> !pop)
		else $error("dispatch during a flush");

endmodule

bind thread_queue exec_stage_properties #(
	.num_threads (num_threads),
	.num_lanes   (num_lanes)
) props_i (
	.clk             (clk),
	.rst             (rst),
	.dispatch_thread (dispatch_thread),
	.pop             (pop),
	.head_valid      (head_valid),
	.full            (full),
	.last_pc         (last_pc),
	.jump_en         (jump_en)
);

/* tests/exec_stage_tb.sv */
`timescale 1ns/1ps

module exec_stage_tb;
	import exec_pkg::*;

	localparam int num_threads = 4;
	localparam int num_lanes   = 2;
	localparam int n_rows      = 31;
	localparam thread_id_t idle_id = thread_id_t'(num_threads);

	logic       clk = 1'b0;
	logic       rst;
	logic       id_valid        [num_threads];
	word_t      id_pc           [num_threads];
	alu_op_e    id_op           [num_threads];
	word_t      id_op1          [num_threads];
	word_t      id_op2          [num_threads];
	word_t      id_imm          [num_threads];
	reg_addr_t  id_rd           [num_threads];
	reg_addr_t  id_rs1          [num_threads];
	reg_addr_t  id_rs2          [num_threads];
	logic       id_stall        [num_threads];
	thread_id_t dispatch_thread [num_lanes];
	logic       wb_en           [num_threads];
	reg_addr_t  wb_rd           [num_threads];
	word_t      wb_data         [num_threads];
	logic       jump_en         [num_threads];
	word_t      jump_addr       [num_threads];

	// stimulus table, one row per cycle
	logic       row_v     [n_rows][num_threads];
	word_t      row_pc    [n_rows][num_threads];
	alu_op_e    row_op    [n_rows][num_threads];
	word_t      row_op1   [n_rows][num_threads];
	word_t      row_op2   [n_rows][num_threads];
	word_t      row_imm   [n_rows][num_threads];
	reg_addr_t  row_rd    [n_rows][num_threads];
	reg_addr_t  row_rs1   [n_rows][num_threads];
	reg_addr_t  row_rs2   [n_rows][num_threads];
	thread_id_t row_disp  [n_rows][num_lanes];
	// results for the cycle after the row, stall for the row's own cycle
	logic       exp_wb    [n_rows][num_threads];
	reg_addr_t  exp_rd    [n_rows][num_threads];
	word_t      exp_data  [n_rows][num_threads];
	logic       exp_jump  [n_rows][num_threads];
	word_t      exp_addr  [n_rows][num_threads];
	logic       exp_stall [n_rows][num_threads];

	integer seed = 82516;

	exec_stage #(
		.num_threads (num_threads),
		.num_lanes   (num_lanes)
	) exec_stage_i (
		.clk             (clk),
		.rst             (rst),
		.id_valid        (id_valid),
		.id_pc           (id_pc),
		.id_op           (id_op),
		.id_op1          (id_op1),
		.id_op2          (id_op2),
		.id_imm          (id_imm),
		.id_rd           (id_rd),
		.id_rs1          (id_rs1),
		.id_rs2          (id_rs2),
		.id_stall        (id_stall),
		.dispatch_thread (dispatch_thread),
		.wb_en           (wb_en),
		.wb_rd           (wb_rd),
		.wb_data         (wb_data),
		.jump_en         (jump_en),
		.jump_addr       (jump_addr)
	);

	always #5 clk = ~clk;

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_stop($sformatf("error: t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_stop($sformatf("error: t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
			fail_stop($sformatf("error: t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	function automatic word_t rnd();
		return word_t'($random(seed));
	endfunction

	task automatic present(input int r, input int t, input word_t pc, input alu_op_e op,
			input word_t a, input word_t b, input word_t imm, input reg_addr_t rd,
			input reg_addr_t rs1, input reg_addr_t rs2);
		row_v[r][t]   = 1'b1;
		row_pc[r][t]  = pc;
		row_op[r][t]  = op;
		row_op1[r][t] = a;
		row_op2[r][t] = b;
		row_imm[r][t] = imm;
		row_rd[r][t]  = rd;
		row_rs1[r][t] = rs1;
		row_rs2[r][t] = rs2;
	endtask

	task automatic dispatch(input int r, input int l, input int t);
		row_disp[r][l] = thread_id_t'(t);
	endtask

	// expected outcome from the opcode rules
	task automatic expect_result(input int r, input int t, input word_t pc, input alu_op_e op,
			input word_t a, input word_t b, input word_t imm, input reg_addr_t rd);
		exp_rd[r][t]   = rd;
		exp_addr[r][t] = pc + imm;
		exp_wb[r][t]   = 1'b1;
		case (op)
			op_add: exp_data[r][t] = a + b;
			op_sub: exp_data[r][t] = a - b;
			op_and: exp_data[r][t] = a & b;
			op_or:  exp_data[r][t] = a | b;
			op_xor: exp_data[r][t] = a ^ b;
			op_slt: exp_data[r][t] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			op_beq: begin
				exp_wb[r][t]   = 1'b0;
				exp_jump[r][t] = (a == b);
			end
			op_bne: begin
				exp_wb[r][t]   = 1'b0;
				exp_jump[r][t] = (a != b);
			end
			default: begin    // jal
				exp_data[r][t] = pc + 32'd4;
				exp_jump[r][t] = 1'b1;
			end
		endcase
	endtask

	task automatic run_op(input int r, input int t, input int l, input word_t pc,
			input alu_op_e op, input reg_addr_t rd);
		word_t a;
		word_t b;
		a = rnd();
		b = rnd();
		present(r, t, pc, op, a, b, 32'h10, rd, 5'd0, 5'd0);
		dispatch(r, l, t);
		expect_result(r, t, pc, op, a, b, 32'h10, rd);
	endtask

	task automatic clear_table();
		for (int r = 0; r < n_rows; r++) begin
			for (int t = 0; t < num_threads; t++) begin
				present(r, t, '0, op_add, '0, '0, '0, '0, '0, '0);
				row_v[r][t]     = 1'b0;
				exp_wb[r][t]    = 1'b0;
				exp_rd[r][t]    = '0;
				exp_data[r][t]  = '0;
				exp_jump[r][t]  = 1'b0;
				exp_addr[r][t]  = '0;
				exp_stall[r][t] = 1'b0;
			end
			for (int l = 0; l < num_lanes; l++)
				row_disp[r][l] = idle_id;
		end
	endtask

	task automatic build_table();
		word_t a [4];
		word_t b [4];
		clear_table();
		// row 0 stays idle, outputs low after reset
		run_op(1, 0, 0, 32'h100, op_add, 5'd1);
		run_op(1, 1, 1, 32'h200, op_sub, 5'd2);
		run_op(2, 0, 0, 32'h104, op_and, 5'd3);
		run_op(2, 1, 1, 32'h204, op_or, 5'd4);
		run_op(3, 0, 0, 32'h108, op_xor, 5'd5);
		run_op(3, 1, 1, 32'h208, op_slt, 5'd6);
		// same instruction held five cycles
		a[0] = rnd();
		b[0] = rnd();
		for (int r = 4; r <= 8; r++)
			present(r, 2, 32'h300, op_add, a[0], b[0], '0, 5'd8, '0, '0);
		dispatch(4, 0, 2);
		expect_result(4, 2, 32'h300, op_add, a[0], b[0], '0, 5'd8);
		// fill thread 3, then drain in order
		for (int i = 0; i < 4; i++) begin
			a[i] = rnd();
			b[i] = rnd();
		end
		present(9, 3, 32'h400, op_add, a[0], b[0], '0, 5'd10, '0, '0);
		present(10, 3, 32'h404, op_sub, a[1], b[1], '0, 5'd11, '0, '0);
		present(11, 3, 32'h408, op_xor, a[2], b[2], '0, 5'd12, '0, '0);
		for (int r = 12; r <= 14; r++)
			present(r, 3, 32'h40c, op_or, a[3], b[3], '0, 5'd13, '0, '0);
		exp_stall[12][3] = 1'b1;
		for (int r = 13; r <= 16; r++)
			dispatch(r, 1, 3);
		expect_result(13, 3, 32'h400, op_add, a[0], b[0], '0, 5'd10);
		expect_result(14, 3, 32'h404, op_sub, a[1], b[1], '0, 5'd11);
		expect_result(15, 3, 32'h408, op_xor, a[2], b[2], '0, 5'd12);
		expect_result(16, 3, 32'h40c, op_or, a[3], b[3], '0, 5'd13);
		// forwarding into a queued rs1 on thread 0
		for (int i = 0; i < 4; i++) begin
			a[i] = rnd();
			b[i] = rnd();
		end
		present(17, 0, 32'h500, op_add, a[0], b[0], '0, 5'd5, '0, '0);
		present(18, 0, 32'h504, op_add, a[1], b[1], '0, 5'd6, 5'd5, '0);
		dispatch(18, 0, 0);
		expect_result(18, 0, 32'h500, op_add, a[0], b[0], '0, 5'd5);
		dispatch(20, 0, 0);
		expect_result(20, 0, 32'h504, op_add, a[0] + b[0], b[1], '0, 5'd6);
		// rd 0 must not forward on thread 1
		present(17, 1, 32'h600, op_add, a[2], b[2], '0, 5'd0, '0, '0);
		dispatch(17, 1, 1);
		expect_result(17, 1, 32'h600, op_add, a[2], b[2], '0, 5'd0);
		present(18, 1, 32'h604, op_add, a[3], b[3], '0, 5'd7, 5'd0, '0);
		dispatch(19, 1, 1);
		expect_result(19, 1, 32'h604, op_add, a[3], b[3], '0, 5'd7);
		// branches and jal on thread 2
		a[0] = rnd();
		b[0] = rnd();
		present(21, 2, 32'h700, op_beq, a[0], a[0], 32'h40, '0, '0, '0);
		dispatch(21, 0, 2);
		expect_result(21, 2, 32'h700, op_beq, a[0], a[0], 32'h40, '0);
		present(23, 2, 32'h710, op_bne, a[0], a[0] + 32'd1, 32'h80, '0, '0, '0);
		dispatch(23, 0, 2);
		expect_result(23, 2, 32'h710, op_bne, a[0], a[0] + 32'd1, 32'h80, '0);
		present(25, 2, 32'h720, op_beq, a[0], a[0] + 32'd1, 32'h20, '0, '0, '0);
		dispatch(25, 0, 2);
		expect_result(25, 2, 32'h720, op_beq, a[0], a[0] + 32'd1, 32'h20, '0);
		present(25, 3, 32'h730, op_bne, b[0], b[0], 32'h20, '0, '0, '0);
		dispatch(25, 1, 3);
		expect_result(25, 3, 32'h730, op_bne, b[0], b[0], 32'h20, '0);
		present(26, 2, 32'h740, op_jal, '0, '0, 32'h100, 5'd9, '0, '0);
		present(27, 2, 32'h744, op_add, a[0], b[0], '0, 5'd14, '0, '0);
		dispatch(27, 0, 2);
		expect_result(27, 2, 32'h740, op_jal, '0, '0, 32'h100, 5'd9);
		present(28, 2, 32'h748, op_add, b[0], a[0], '0, 5'd15, '0, '0);    // dropped by flush
		a[1] = rnd();
		b[1] = rnd();
		present(29, 2, 32'h840, op_add, a[1], b[1], '0, 5'd16, '0, '0);    // jump target
		dispatch(29, 0, 2);
		expect_result(29, 2, 32'h840, op_add, a[1], b[1], '0, 5'd16);
	endtask

	task automatic drive_row(input int r);
		for (int t = 0; t < num_threads; t++) begin
			id_valid[t] <= row_v[r][t];
			id_pc[t]    <= row_pc[r][t];
			id_op[t]    <= row_op[r][t];
			id_op1[t]   <= row_op1[r][t];
			id_op2[t]   <= row_op2[r][t];
			id_imm[t]   <= row_imm[r][t];
			id_rd[t]    <= row_rd[r][t];
			id_rs1[t]   <= row_rs1[r][t];
			id_rs2[t]   <= row_rs2[r][t];
		end
		for (int l = 0; l < num_lanes; l++)
			dispatch_thread[l] <= row_disp[r][l];
	endtask

	task automatic check_results(input int r);
		for (int t = 0; t < num_threads; t++) begin
			check_bit($sformatf("wb_en[%0d]", t), wb_en[t], exp_wb[r][t]);
			check_bit($sformatf("jump_en[%0d]", t), jump_en[t], exp_jump[r][t]);
			if (exp_wb[r][t]) begin
				check_reg($sformatf("wb_rd[%0d]", t), wb_rd[t], exp_rd[r][t]);
				check_word($sformatf("wb_data[%0d]", t), wb_data[t], exp_data[r][t]);
			end
			if (exp_jump[r][t])
				check_word($sformatf("jump_addr[%0d]", t), jump_addr[t], exp_addr[r][t]);
		end
	endtask

	task automatic wait_ready();
		logic busy;
		for (int n = 0; n < 20; n++) begin
			@(negedge clk);
			busy = 1'b0;
			for (int t = 0; t < num_threads; t++)
				busy = busy | id_stall[t] | wb_en[t] | jump_en[t];
			if (rst && !busy)
				return;
		end
		fail_stop("outputs did not settle low after reset");
	endtask

	initial begin
		rst = 1'b0;
		for (int t = 0; t < num_threads; t++) begin
			id_valid[t] = 1'b0;
			id_pc[t]    = '0;
			id_op[t]    = op_add;
			id_op1[t]   = '0;
			id_op2[t]   = '0;
			id_imm[t]   = '0;
			id_rd[t]    = '0;
			id_rs1[t]   = '0;
			id_rs2[t]   = '0;
		end
		for (int l = 0; l < num_lanes; l++)
			dispatch_thread[l] = idle_id;
		build_table();
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		wait_ready();
		for (int k = 0; k <= n_rows; k++) begin
			@(posedge clk);
			if (k < n_rows)
				drive_row(k);
			else
				clear_inputs();
			@(negedge clk);
			if (k < n_rows) begin
				for (int t = 0; t < num_threads; t++)
					check_bit($sformatf("id_stall[%0d]", t), id_stall[t], exp_stall[k][t]);
			end
			if (k > 0)
				check_results(k - 1);
		end
		$display(">>> PASS");
		$finish;
	end

	task automatic clear_inputs();
		for (int t = 0; t < num_threads; t++)
			id_valid[t] <= 1'b0;
		for (int l = 0; l < num_lanes; l++)
			dispatch_thread[l] <= idle_id;
	endtask

	// watchdog for the whole run
	initial begin
		for (int n = 0; n < 2000; n++)
			@(posedge clk);
		fail_stop("simulation timed out");
	end

endmodule
